// ==== project.f ====
src/ac_pkg.sv
src/ac_beat_if.sv
src/ac_session_ctrl.sv
src/ac_pixel_fifo.sv
src/ac_stream_out.sv
src/access_control.sv
verif/ac_assert.sv
verif/tb_access_control.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the result from the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module tb_access_control -Mdir obj_dir -f project.f \
	&& ./obj_dir/Vtb_access_control 2>&1 | tee sim.log \
	|| { echo "Build or simulation did not complete"; exit 1; }

grep -qx "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== src/ac_beat_if.sv ====
// Read port between the beat FIFO and the stream-out stage
// Empty flag and read data flow out of the FIFO
// Read strobe and flush flow back from the stream side

interface ac_beat_if;
	import ac_pkg::*;

	// No beat waiting in the FIFO
	logic  empty;
	// Beat fetched by the most recent read strobe
	beat_t rdata;
	// Single-cycle read request
	logic  rd;
	// Drop everything still buffered
	logic  flush;

	modport fifo_side (
		output empty,
		output rdata,
		input  rd,
		input  flush
	);

	modport out_side (
		input  empty,
		input  rdata,
		output rd,
		output flush
	);

endinterface

// ==== src/ac_pixel_fifo.sv ====
// Beat FIFO behind the up-sampler write port
// Admits pushes only inside the session window
// Circular buffer with read and write pointers and a fill count
// Registered read data and a synchronous flush

module ac_pixel_fifo (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          window,
	input  logic          upsp_wvalid,
	input  ac_pkg::beat_t upsp_wdata,
	output logic          upsp_wready,
	ac_beat_if.fifo_side  beat
);
	import ac_pkg::*;

	beat_t     mem [FIFO_DEPTH];
	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;
	fifo_cnt_t fill;

	logic full;
	logic wr_en;
	logic rd_en;

	// Pointer advance with wrap at the buffer end
	function automatic fifo_ptr_t ptr_inc(fifo_ptr_t p);
		if (p == fifo_ptr_t'(FIFO_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign full        = (fill == fifo_cnt_t'(FIFO_DEPTH));
	assign beat.empty  = (fill == '0);

	// Ready is shown outside the window too, such beats are dropped
	assign upsp_wready = ~full;
	assign wr_en       = upsp_wvalid & ~full & window;
	assign rd_en       = beat.rd & ~beat.empty;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else if (beat.flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= ptr_inc(wr_ptr);
			if (rd_en)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({wr_en, rd_en})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// Storage array
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= upsp_wdata;
	end

	// Read beat is held until the next strobe
	always_ff @(posedge clk) begin
		if (rd_en)
			beat.rdata <= mem[rd_ptr];
	end

endmodule

// ==== src/ac_pkg.sv ====
// Shared definitions for the up-sampling access controller
// Pixel and beat widths, frame geometry, FIFO sizing
// Vector types for beats, register words and counters
// Session controller state encoding

package ac_pkg;

	// Pixel and beat format
	localparam int PIXEL_BITS      = 24;
	localparam int PIXELS_PER_BEAT = 4;
	localparam int BEAT_BITS       = PIXEL_BITS * PIXELS_PER_BEAT;

	// Destination frame geometry
	localparam int ROW_PIXELS  = 16;
	localparam int ROW_BEATS   = ROW_PIXELS / PIXELS_PER_BEAT;
	localparam int FRAME_ROWS  = 4;
	localparam int FRAME_BEATS = ROW_BEATS * FRAME_ROWS;

	// Output buffer size in beats
	localparam int FIFO_DEPTH = 8;

	// Control register file word
	localparam int CRF_BITS = 32;

	typedef logic [PIXEL_BITS-1:0] pixel_t;
	typedef logic [BEAT_BITS-1:0]  beat_t;
	typedef logic [CRF_BITS-1:0]   crf_word_t;

	// Beat position inside a row and inside a frame
	typedef logic [$clog2(ROW_BEATS)-1:0]   row_cnt_t;
	typedef logic [$clog2(FRAME_BEATS)-1:0] frame_cnt_t;

	// FIFO addressing and fill level
	typedef logic [$clog2(FIFO_DEPTH)-1:0]   fifo_ptr_t;
	typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_cnt_t;

	// Frame session phases
	typedef enum logic [1:0] {
		st_idle,
		st_active,
		st_draining,
		st_closing
	} session_state_t;

endpackage

// ==== src/ac_session_ctrl.sv ====
// Frame session controller
// Tracks the upstart/upend handshake with the register file
// Opens the up-sampler time window and closes it at frame end
// Writes back the clear-start and set-end register values

module ac_session_ctrl (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              crf_upstart,
	input  logic              crf_upend,
	input  logic              frame_done,
	output logic              window,
	output logic              processing,
	output logic              crf_wrt,
	output ac_pkg::crf_word_t crf_wdata
);
	import ac_pkg::*;

	session_state_t state;
	session_state_t state_nxt;

	logic start_req;
	logic end_ack;
	logic bits_clear;
	logic wr_clear_start;
	logic wr_set_end;

	// Register bit combinations seen from the host
	assign start_req  = crf_upstart & ~crf_upend;
	assign end_ack    = ~crf_upstart & crf_upend;
	assign bits_clear = ~crf_upstart & ~crf_upend;

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (start_req)
					state_nxt = st_active;
			end
			st_active: begin
				if (end_ack)
					state_nxt = st_idle;
				else if (frame_done)
					state_nxt = st_draining;
			end
			st_draining: begin
				// Waiting for the host to drop upstart
				if (end_ack)
					state_nxt = st_idle;
				else if (bits_clear)
					state_nxt = st_closing;
			end
			st_closing: begin
				if (end_ack)
					state_nxt = st_idle;
			end
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= st_idle;
		else
			state <= state_nxt;
	end

	assign processing = (state != st_idle);
	// Up-sampler may push only while the frame is running
	assign window     = (state == st_active);

	// Write-back requests, clearing upstart takes priority
	assign wr_clear_start = processing & frame_done & crf_upstart;
	assign wr_set_end     = processing & bits_clear;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			crf_wrt <= 1'b0;
		else
			crf_wrt <= wr_clear_start | wr_set_end;
	end

	always_ff @(posedge clk) begin
		if (wr_clear_start)
			crf_wdata <= '0;
		else if (wr_set_end)
			// Upend set and upstart left clear
			crf_wdata <= crf_word_t'(2);
	end

endmodule

// ==== src/ac_stream_out.sv ====
// AXI-Stream output stage of the access controller
// Pulls beats from the FIFO when the output register can take one
// Row and frame beat counters for tlast and frame end
// Output valid/last register and pixel order reversal

module ac_stream_out (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          window,
	ac_beat_if.out_side   beat,
	input  logic          m_axis_tready,
	output logic          m_axis_tvalid,
	output logic          m_axis_tlast,
	output ac_pkg::beat_t m_axis_tdata,
	output logic          frame_done
);
	import ac_pkg::*;

	row_cnt_t   row_cnt;
	frame_cnt_t frame_cnt;

	logic accept;
	logic row_end;
	logic frame_end;

	// Mirror the pixel order inside one beat
	function automatic beat_t reverse_pixels(beat_t b);
		beat_t  r;
		pixel_t px;
		r = '0;
		for (int i = 0; i < PIXELS_PER_BEAT; i++) begin
			px = b[(PIXELS_PER_BEAT-1-i)*PIXEL_BITS +: PIXEL_BITS];
			r[i*PIXEL_BITS +: PIXEL_BITS] = px;
		end
		return r;
	endfunction

	// Read when the output register is free or drains this cycle
	assign beat.rd = ~beat.empty & window & (~m_axis_tvalid | m_axis_tready);

	assign accept    = m_axis_tvalid & m_axis_tready;
	assign row_end   = (row_cnt == row_cnt_t'(ROW_BEATS - 1));
	assign frame_end = (frame_cnt == frame_cnt_t'(FRAME_BEATS - 1));

	// Leftover beats are dropped once the frame completes
	assign beat.flush = frame_done;

	// Position of the next fetched beat within its row
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			row_cnt <= '0;
		else if (frame_done)
			row_cnt <= '0;
		else if (beat.rd)
			row_cnt <= row_end ? '0 : row_cnt + 1'b1;
	end

	// Accepted beats within the frame
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			frame_cnt <= '0;
		else if (frame_done)
			frame_cnt <= '0;
		else if (accept)
			frame_cnt <= frame_end ? '0 : frame_cnt + 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			frame_done <= 1'b0;
		else
			frame_done <= accept & m_axis_tlast & frame_end;
	end

	// Output register control, data itself sits in the FIFO read register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_axis_tvalid <= 1'b0;
			m_axis_tlast  <= 1'b0;
		end else if (beat.rd) begin
			m_axis_tvalid <= 1'b1;
			m_axis_tlast  <= row_end;
		end else if (m_axis_tready) begin
			m_axis_tvalid <= 1'b0;
			m_axis_tlast  <= 1'b0;
		end
	end

	// Output pixel 0 is input pixel 3
	assign m_axis_tdata = reverse_pixels(beat.rdata);

endmodule

// ==== src/access_control.sv ====
// Top level of the up-sampling access controller
// Session controller steering a beat FIFO and a stream-out stage
// Up-sampler write port, AXI-Stream master port, register write-back

module access_control (
	input  logic              clk,
	input  logic              rst_n,

	// Register file
	input  logic              crf_upstart,
	input  logic              crf_upend,
	output logic              crf_wrt,
	output ac_pkg::crf_word_t crf_wdata,
	output logic              processing,

	// Up-sampler write side
	input  logic              upsp_wvalid,
	input  ac_pkg::beat_t     upsp_wdata,
	output logic              upsp_wready,

	// AXI-Stream master
	output logic              m_axis_tvalid,
	input  logic              m_axis_tready,
	output ac_pkg::beat_t     m_axis_tdata,
	output logic              m_axis_tlast
);

	logic window;
	logic frame_done;

	ac_beat_if u_beat_if ();

	ac_session_ctrl u_session_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.crf_upstart (crf_upstart),
		.crf_upend   (crf_upend),
		.frame_done  (frame_done),
		.window      (window),
		.processing  (processing),
		.crf_wrt     (crf_wrt),
		.crf_wdata   (crf_wdata)
	);

	ac_pixel_fifo u_pixel_fifo (
		.clk         (clk),
		.rst_n       (rst_n),
		.window      (window),
		.upsp_wvalid (upsp_wvalid),
		.upsp_wdata  (upsp_wdata),
		.upsp_wready (upsp_wready),
		.beat        (u_beat_if.fifo_side)
	);

	ac_stream_out u_stream_out (
		.clk           (clk),
		.rst_n         (rst_n),
		.window        (window),
		.beat          (u_beat_if.out_side),
		.m_axis_tready (m_axis_tready),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tdata  (m_axis_tdata),
		.frame_done    (frame_done)
	);

endmodule

// ==== verif/ac_assert.sv ====
// Concurrent checks on the AXI-Stream and register ports
// Bound into the access controller top level

module ac_assert (
	input logic          clk,
	input logic          rst_n,
	input logic          processing,
	input logic          m_axis_tvalid,
	input logic          m_axis_tready,
	input ac_pkg::beat_t m_axis_tdata,
	input logic          m_axis_tlast
);

	// A stalled beat holds until the sink takes it
	property stall_holds;
		@(posedge clk) disable iff (!rst_n)
		m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata);
	endproperty

	property last_needs_valid;
		@(posedge clk) disable iff (!rst_n)
		m_axis_tlast |-> m_axis_tvalid;
	endproperty

	// No output outside a session
	property idle_quiet;
		@(posedge clk) disable iff (!rst_n)
		!processing |-> !m_axis_tvalid;
	endproperty

	a_stall_holds: assert property (stall_holds)
		else $error("Stream beat changed or vanished while tready was low");
	a_last_needs_valid: assert property (last_needs_valid)
		else $error("tlast was high without tvalid");
	a_idle_quiet: assert property (idle_quiet)
		else $error("tvalid was high while processing was low");

endmodule

bind access_control ac_assert u_ac_assert (
	.clk           (clk),
	.rst_n         (rst_n),
	.processing    (processing),
	.m_axis_tvalid (m_axis_tvalid),
	.m_axis_tready (m_axis_tready),
	.m_axis_tdata  (m_axis_tdata),
	.m_axis_tlast  (m_axis_tlast)
);

// ==== verif/tb_access_control.sv ====
// Testbench for the up-sampling access controller
// Clock, reset, register file model and AXI-Stream ready patterns
// Frame stimulus table applied in a loop, scoreboard on the stream port
// Closing line with the error counts and the result

module tb_access_control;
	import ac_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int WAIT_LIMIT   = 2000;
	localparam int NUM_FRAMES   = 3;

	typedef enum int {rdy_always, rdy_alternate, rdy_stall} ready_mode_t;

	// Ready pattern, beats offered before the window, FIFO expected to fill
	typedef struct {
		ready_mode_t mode;
		int          drop_cnt;
		logic        expect_full;
	} frame_entry_t;

	logic      clk = 1'b0;
	logic      rst_n;
	logic      crf_upstart = 1'b0;
	logic      crf_upend = 1'b0;
	logic      crf_wrt;
	crf_word_t crf_wdata;
	logic      processing;
	logic      upsp_wvalid;
	beat_t     upsp_wdata;
	logic      upsp_wready;
	logic      m_axis_tvalid;
	logic      m_axis_tready = 1'b0;
	beat_t     m_axis_tdata;
	logic      m_axis_tlast;

	frame_entry_t frame_table [NUM_FRAMES];
	ready_mode_t  ready_mode = rdy_always;
	logic [31:0]  lcg_state = 32'd45739;
	int           ready_cyc = 0;
	int           start_req = 0;
	int           start_done = 0;
	logic         timed_out = 1'b0;
	int           in_cnt = 0;
	int           out_cnt = 0;
	int           full_cnt = 0;
	int           mon_mismatch = 0;
	int           mon_other = 0;
	int           chk_mismatch = 0;
	int           chk_other = 0;
	beat_t        exp_q[$];
	beat_t        dropped_q[$];
	crf_word_t    wr_log[$];

	access_control u_access_control (.*);

	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic beat_t make_beat();
		beat_t       b;
		logic [31:0] r;
		for (int i = 0; i < PIXELS_PER_BEAT; i++) begin
			r = lcg_next();
			b[i*PIXEL_BITS +: PIXEL_BITS] = r[31:8];
		end
		return b;
	endfunction

	// Input pixel 3 lands in output pixel 0
	function automatic beat_t mirror_beat(beat_t b);
		return {b[23:0], b[47:24], b[71:48], b[95:72]};
	endfunction

	function automatic logic ready_for(ready_mode_t m, int cyc);
		case (m)
			rdy_alternate: return cyc[0];
			rdy_stall:     return (cyc % 8) >= 6;
			default:       return 1'b1;
		endcase
	endfunction

	always @(posedge clk) begin
		#1;
		m_axis_tready = ready_for(ready_mode, ready_cyc);
		ready_cyc++;
	end

	// Register file, loads write-backs and session start requests
	always @(posedge clk) begin
		#1;
		if (crf_wrt === 1'b1) begin
			crf_upstart = crf_wdata[0];
			crf_upend   = crf_wdata[1];
		end else if (start_req != start_done) begin
			crf_upstart = 1'b1;
			crf_upend   = 1'b0;
			start_done  = start_req;
		end
	end

	// Scoreboard, sampled mid-cycle where every signal is settled
	always @(negedge clk) begin
		int    fill;
		logic  exp_last;
		beat_t exp_beat;
		if (rst_n) begin
			// Beats held in the FIFO, the output register holds one more
			fill = in_cnt - out_cnt - (m_axis_tvalid ? 1 : 0);
			if (fill == FIFO_DEPTH)
				full_cnt++;
			assert (upsp_wready == (fill < FIFO_DEPTH)) else begin
				$display("Mismatch upsp_wready: got %h, expected %h", upsp_wready,
					fill < FIFO_DEPTH);
				mon_mismatch++;
			end
			if (upsp_wvalid && upsp_wready) begin
				if (processing) begin
					exp_q.push_back(mirror_beat(upsp_wdata));
					in_cnt++;
				end else
					dropped_q.push_back(mirror_beat(upsp_wdata));
			end
			if (m_axis_tvalid && m_axis_tready) begin
				exp_last = (out_cnt % ROW_BEATS) == (ROW_BEATS - 1);
				assert (m_axis_tlast == exp_last) else begin
					$display("Mismatch m_axis_tlast: got %h, expected %h", m_axis_tlast, exp_last);
					mon_mismatch++;
				end
				foreach (dropped_q[i])
					assert (m_axis_tdata != dropped_q[i]) else begin
						$display("A beat offered outside the window reached the output");
						mon_other++;
					end
				assert (exp_q.size() > 0) else begin
					$display("An output beat appeared with no admitted beat pending");
					mon_other++;
				end
				if (exp_q.size() > 0) begin
					exp_beat = exp_q.pop_front();
					assert (m_axis_tdata == exp_beat) else begin
						$display("Mismatch m_axis_tdata: got %h, expected %h", m_axis_tdata,
							exp_beat);
						mon_mismatch++;
					end
				end
				out_cnt++;
			end
			if (crf_wrt)
				wr_log.push_back(crf_wdata);
		end
	end

	task automatic report_timeout(string what);
		$display("Timeout: %s", what);
		timed_out = 1'b1;
		chk_other++;
	endtask

	task automatic wait_processing(logic level, string what);
		int n;
		n = 0;
		while (processing !== level && n < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (processing === level) else report_timeout(what);
	endtask

	// Beats offered while the window is closed
	task automatic offer_outside(int count);
		for (int i = 0; i < count; i++) begin
			upsp_wvalid = 1'b1;
			upsp_wdata  = make_beat();
			@(posedge clk);
			#1;
		end
		upsp_wvalid = 1'b0;
	endtask

	task automatic push_frame();
		int sent;
		int n;
		sent = 0;
		while (sent < FRAME_BEATS && !timed_out) begin
			upsp_wvalid = 1'b1;
			upsp_wdata  = make_beat();
			n = 0;
			while (!upsp_wready && n < WAIT_LIMIT) begin
				@(posedge clk);
				#1;
				n++;
			end
			assert (upsp_wready) else report_timeout("upsp_wready never rose while pushing");
			@(posedge clk);
			#1;
			sent++;
		end
		upsp_wvalid = 1'b0;
	endtask

	task automatic wait_frame_out(int base);
		int n;
		n = 0;
		while (out_cnt - base < FRAME_BEATS && n < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (out_cnt - base >= FRAME_BEATS)
			else report_timeout("the last beat of the frame never left the stream port");
	endtask

	task automatic check_frame(int idx, frame_entry_t e, int out_base, int log_base,
		int full_base);
		assert (out_cnt - out_base == FRAME_BEATS) else begin
			$display("Frame %0d carried %0d beats instead of %0d", idx, out_cnt - out_base,
				FRAME_BEATS);
			chk_other++;
		end
		assert (exp_q.size() == 0) else begin
			$display("Frame %0d lost %0d admitted beats", idx, exp_q.size());
			chk_other++;
		end
		assert (wr_log.size() - log_base == 2) else begin
			$display("Frame %0d saw %0d register write-backs instead of 2", idx,
				wr_log.size() - log_base);
			chk_other++;
		end
		if (wr_log.size() - log_base == 2) begin
			assert (wr_log[log_base] == 32'h0) else begin
				$display("Mismatch crf_wdata: got %h, expected %h", wr_log[log_base], 32'h0);
				chk_mismatch++;
			end
			assert (wr_log[log_base + 1] == 32'h2) else begin
				$display("Mismatch crf_wdata: got %h, expected %h", wr_log[log_base + 1], 32'h2);
				chk_mismatch++;
			end
		end
		if (e.expect_full)
			assert (full_cnt > full_base) else begin
				$display("Frame %0d never filled the FIFO with eight beats", idx);
				chk_other++;
			end
	endtask

	task automatic run_frame(int idx);
		frame_entry_t e;
		int           out_base;
		int           log_base;
		int           full_base;
		e         = frame_table[idx];
		out_base  = out_cnt;
		log_base  = wr_log.size();
		full_base = full_cnt;
		@(negedge clk);
		ready_mode = e.mode;
		@(posedge clk);
		#1;
		offer_outside(e.drop_cnt);
		@(negedge clk);
		start_req++;
		wait_processing(1'b1, "processing never rose after upstart was set");
		if (!timed_out)
			push_frame();
		if (!timed_out)
			wait_frame_out(out_base);
		if (!timed_out)
			wait_processing(1'b0, "processing never fell after the frame");
		if (!timed_out)
			check_frame(idx, e, out_base, log_base, full_base);
	endtask

	initial begin
		rst_n       = 1'b0;
		upsp_wvalid = 1'b0;
		upsp_wdata  = '0;
		frame_table[0] = '{rdy_always, 3, 1'b0};
		frame_table[1] = '{rdy_alternate, 0, 1'b0};
		frame_table[2] = '{rdy_stall, 5, 1'b1};
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			if (!timed_out)
				run_frame(f);
		end
		$display("Errors: %0d mismatches, %0d other failures", mon_mismatch + chk_mismatch,
			mon_other + chk_other);
		if (mon_mismatch + chk_mismatch + mon_other + chk_other == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
